//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build gfx_soc_tb with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	rm -f $(LOG)
	verilator --binary --timing --assert -Wno-fatal --top-module gfx_soc_tb \
		-f gfx_soc.f -Mdir obj_dir -o gfx_soc_sim
	./obj_dir/gfx_soc_sim 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- gfx_soc.f
src/gfx_pkg.sv
src/sys_ram.sv
src/gpu_regs.sv
src/blit_engine.sv
src/frame_buffer.sv
src/gfx_soc.sv
sim/gfx_soc_tb.sv

//--- sim/gfx_soc_tb.sv
`timescale 1ns/1ps

module gfx_soc_tb;

    localparam int MEM_SIZE     = 8192;
    localparam int FB_WIDTH     = 64;
    localparam int FB_HEIGHT    = 48;
    localparam int FB_PIXELS    = FB_WIDTH * FB_HEIGHT;
    localparam int BUS_TIMEOUT  = 20;
    localparam int IDLE_TIMEOUT = 4000;

    logic            clk_25mhz;
    logic            arst_n;
    logic            mem_valid;
    logic [31:0]     mem_addr;
    logic [31:0]     mem_wdata;
    logic [3:0]      mem_wstrb;
    logic            mem_ready;
    logic [31:0]     mem_rdata;
    logic            vsync;
    logic [5:0]      scan_x;
    logic [5:0]      scan_y;
    gfx_pkg::pixel_t scan_pixel;

    // Reference model state.
    logic [31:0]     ram_model [0:MEM_SIZE/4-1];
    gfx_pkg::pixel_t fb_model [0:1][0:FB_PIXELS-1];
    logic            front_model;

    integer          seed;
    string           cur_test;
    int              test_errors;
    int              total_errors;
    int              tests_run;
    int              tests_failed;

    gfx_soc #(
        .MEM_SIZE (MEM_SIZE),
        .FB_WIDTH (FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT)
    ) i_dut (
        .clk_25mhz (clk_25mhz),
        .arst_n    (arst_n),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .vsync     (vsync),
        .scan_x    (scan_x),
        .scan_y    (scan_y),
        .scan_pixel(scan_pixel)
    );

    initial begin
        clk_25mhz = 1'b0;
        forever #20 clk_25mhz = ~clk_25mhz;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] reg_addr(input gfx_pkg::reg_offset_e off);
        return 32'(MEM_SIZE) + 32'(off);
    endfunction

    task automatic abort_run(input string why);
        $display("error: %s", why);
        $display("Result: FAILED");
        $finish;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk_25mhz);
            #2;
        end
    endtask

    // Called 2 ns after a rising edge; returns at the same phase.
    task automatic bus_transfer(input logic [31:0] addr, input logic [31:0] wdata,
                                input logic [3:0] wstrb, output logic [31:0] rdata);
        int waited;
        mem_valid = 1'b1;
        mem_addr  = addr;
        mem_wdata = wdata;
        mem_wstrb = wstrb;
        waited    = 0;
        do begin
            @(posedge clk_25mhz);
            #2;
            waited++;
        end while (!mem_ready && waited < BUS_TIMEOUT);
        if (!mem_ready) begin
            abort_run($sformatf("bus gave no ready for address %08h", addr));
        end else begin
            rdata     = mem_rdata;
            mem_valid = 1'b0;
            mem_wstrb = 4'd0;
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        logic [31:0] unused;
        bus_transfer(addr, data, strb, unused);
        if (addr < 32'(MEM_SIZE)) begin
            for (int i = 0; i < 4; i++) begin
                if (strb[i]) begin
                    ram_model[addr / 4][8*i +: 8] = data[8*i +: 8];
                end
            end
        end
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        bus_transfer(addr, 32'd0, 4'd0, data);
    endtask

    task automatic set_reg(input gfx_pkg::reg_offset_e off, input logic [31:0] data);
        bus_write(reg_addr(off), data, 4'hf);
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        int          polls;
        polls = 0;
        do begin
            bus_read(reg_addr(gfx_pkg::BUSY), status);
            polls++;
        end while (status[0] && polls < IDLE_TIMEOUT);
        if (status[0]) begin
            abort_run("blit engine stayed busy past the time limit");
        end
    endtask

    task automatic read_scan(input int x, input int y, output gfx_pkg::pixel_t pix);
        scan_x = 6'(x);
        scan_y = 6'(y);
        @(posedge clk_25mhz);
        #2;
        pix = scan_pixel;
    endtask

    task automatic check_word(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected %08h, actual %08h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_pixel(input string what, input gfx_pkg::pixel_t exp,
                               input gfx_pkg::pixel_t act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected %04h, actual %04h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d errors", cur_test, test_errors);
            tests_failed++;
        end
    endtask

    task automatic model_clear(input gfx_pkg::pixel_t color);
        for (int i = 0; i < FB_PIXELS; i++) begin
            fb_model[!front_model][i] = color;
        end
    endtask

    // Clipped copy into the back buffer; even halfwords take the low half.
    task automatic model_draw(input int base, input int ax, input int ay, input int iw,
                              input int w, input int h, input int x, input int y);
        int          b;
        logic [31:0] word;
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < w; c++) begin
                if ((x + c < FB_WIDTH) && (y + r < FB_HEIGHT)) begin
                    b    = base + 2 * ((ay + r) * iw + ax + c);
                    word = ram_model[b / 4];
                    fb_model[!front_model][(y + r) * FB_WIDTH + x + c] =
                        ((b & 2) != 0) ? word[31:16] : word[15:0];
                end
            end
        end
    endtask

    task automatic issue_clear(input gfx_pkg::pixel_t color);
        set_reg(gfx_pkg::CLEAR_COLOR, 32'(color));
        set_reg(gfx_pkg::CLEAR, 32'd1);
        model_clear(color);
    endtask

    // Immediate swap, then the flip settles before scanning.
    task automatic swap_now();
        set_reg(gfx_pkg::SWAP, 32'd1);
        front_model = !front_model;
        wait_cycles(3);
    endtask

    task automatic check_screen();
        gfx_pkg::pixel_t pix;
        for (int y = 0; y < FB_HEIGHT; y++) begin
            for (int x = 0; x < FB_WIDTH; x++) begin
                read_scan(x, y, pix);
                check_pixel($sformatf("pixel %0d,%0d", x, y),
                            fb_model[front_model][y * FB_WIDTH + x], pix);
            end
        end
    endtask

    initial begin
        logic [31:0]     addr_list [0:39];
        logic [31:0]     got;
        gfx_pkg::pixel_t pix;
        gfx_pkg::pixel_t color;
        int              d_base;
        int              d_ax;
        int              d_ay;
        int              d_iw;
        int              d_w;
        int              d_h;
        int              d_x;
        int              d_y;

        seed         = 32'hb76d4abf;
        arst_n       = 1'b0;
        mem_valid    = 1'b0;
        mem_addr     = 32'd0;
        mem_wdata    = 32'd0;
        mem_wstrb    = 4'd0;
        vsync        = 1'b0;
        scan_x       = 6'd0;
        scan_y       = 6'd0;
        front_model  = 1'b0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (16) @(posedge clk_25mhz);
        #2;
        arst_n = 1'b1;
        wait_cycles(2);

        begin_test("ram_access");
        for (int i = 0; i < 40; i++) begin
            addr_list[i] = 32'(rand_below(256) * 4);
            bus_write(addr_list[i], $random(seed), 4'hf);
        end
        for (int i = 0; i < 40; i++) begin
            bus_write(addr_list[i], $random(seed), 4'($random(seed)));
        end
        for (int i = 0; i < 40; i++) begin
            bus_read(addr_list[i], got);
            check_word($sformatf("ram %08h", addr_list[i]), ram_model[addr_list[i] / 4], got);
        end
        bus_write(32'(MEM_SIZE) + 32'h200, 32'hffff_ffff, 4'hf);
        bus_read(32'(MEM_SIZE) + 32'h200, got);
        check_word("unmapped register", 32'd0, got);
        bus_write(32'h0001_0000, 32'hffff_ffff, 4'hf);
        bus_read(32'h0001_0000, got);
        check_word("unmapped space", 32'd0, got);
        end_test();

        begin_test("clear_swap");
        set_reg(gfx_pkg::VSYNCED, 32'd0);
        color = 16'(rand_below(65536));
        issue_clear(color);
        wait_idle();
        swap_now();
        check_screen();
        end_test();

        begin_test("draw_clip");
        for (int i = 0; i < 768; i++) begin
            bus_write(32'h1000 + 32'(4 * i), $random(seed), 4'hf);
        end
        issue_clear(16'(rand_below(65536)));
        wait_idle();
        for (int k = 0; k < 3; k++) begin
            d_base = 32'h1000 + 2 * rand_below(8);
            d_ax   = rand_below(8);
            d_ay   = rand_below(4);
            d_iw   = 16 + rand_below(49);
            d_w    = 1 + rand_below(24);
            d_h    = 1 + rand_below(16);
            d_x    = rand_below(80);
            d_y    = rand_below(60);
            // First draw crosses the right edge, second the bottom edge.
            if (k == 0) begin
                d_x = FB_WIDTH - 4;
                d_y = rand_below(FB_HEIGHT - 16);
                d_w = 8 + rand_below(17);
            end
            if (k == 1) begin
                d_x = rand_below(FB_WIDTH - 24);
                d_y = FB_HEIGHT - 3;
                d_h = 6 + rand_below(11);
            end
            set_reg(gfx_pkg::ADDR, 32'(d_base));
            set_reg(gfx_pkg::ADDR_X, 32'(d_ax));
            set_reg(gfx_pkg::ADDR_Y, 32'(d_ay));
            set_reg(gfx_pkg::IMG_WIDTH, 32'(d_iw));
            set_reg(gfx_pkg::WIDTH, 32'(d_w));
            set_reg(gfx_pkg::HEIGHT, 32'(d_h));
            set_reg(gfx_pkg::X, 32'(d_x));
            set_reg(gfx_pkg::Y, 32'(d_y));
            set_reg(gfx_pkg::DRAW, 32'd1);
            model_draw(d_base, d_ax, d_ay, d_iw, d_w, d_h, d_x, d_y);
            wait_idle();
        end
        swap_now();
        check_screen();
        end_test();

        // The draw lands mid-clear and must be dropped.
        begin_test("busy_draw");
        set_reg(gfx_pkg::X, 32'd0);
        set_reg(gfx_pkg::Y, 32'd0);
        issue_clear(16'(rand_below(65536)));
        bus_read(reg_addr(gfx_pkg::BUSY), got);
        check_word("busy after clear", 32'd1, got);
        set_reg(gfx_pkg::DRAW, 32'd1);
        wait_idle();
        bus_read(reg_addr(gfx_pkg::BUSY), got);
        check_word("busy after idle", 32'd0, got);
        swap_now();
        check_screen();
        end_test();

        begin_test("vsync_swap");
        set_reg(gfx_pkg::VSYNCED, 32'd1);
        issue_clear(fb_model[front_model][0] ^ 16'h5a5a);
        wait_idle();
        set_reg(gfx_pkg::SWAP, 32'd1);
        set_reg(gfx_pkg::SWAP, 32'd1);
        wait_cycles(8);
        read_scan(0, 0, pix);
        check_pixel("front before vsync", fb_model[front_model][0], pix);
        bus_read(reg_addr(gfx_pkg::VSYNC), got);
        check_word("vsync low", 32'd0, got);
        vsync = 1'b1;
        wait_cycles(6);
        front_model = !front_model;
        read_scan(5, 7, pix);
        check_pixel("front after vsync", fb_model[front_model][7 * FB_WIDTH + 5], pix);
        bus_read(reg_addr(gfx_pkg::VSYNC), got);
        check_word("vsync high", 32'd1, got);
        vsync = 1'b0;
        wait_cycles(6);
        bus_read(reg_addr(gfx_pkg::VSYNC), got);
        check_word("vsync low again", 32'd0, got);
        read_scan(9, 3, pix);
        check_pixel("front stays", fb_model[front_model][3 * FB_WIDTH + 9], pix);
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- src/blit_engine.sv
`timescale 1ns/1ps

module blit_engine #(
    parameter int  MEM_SIZE  = 8192,
    parameter int  FB_WIDTH  = 64,
    parameter int  FB_HEIGHT = 48,
    localparam int AW        = $clog2(MEM_SIZE / 4),
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT,
    localparam int FBAW      = $clog2(FB_PIXELS)
) (
    input  logic            clk_25mhz,
    input  logic            arst_n,
    input  logic            draw,
    input  logic            clear,
    input  logic [31:0]     src_addr,
    input  logic [15:0]     src_x,
    input  logic [15:0]     src_y,
    input  logic [15:0]     img_width,
    input  logic [10:0]     width,
    input  logic [9:0]      height,
    input  logic [10:0]     dst_x,
    input  logic [9:0]      dst_y,
    input  gfx_pkg::pixel_t clear_color,
    output logic            busy,
    output logic            src_rd_en,
    output logic [AW-1:0]   src_rd_addr,
    input  logic [31:0]     src_rd_data,
    output logic            fb_we,
    output logic [FBAW-1:0] fb_addr,
    output gfx_pkg::pixel_t fb_pixel
);

    gfx_pkg::blit_state_e state;

    logic            start;
    logic            advance;
    logic [31:0]     base_q;
    logic [15:0]     sx_q;
    logic [15:0]     sy_q;
    logic [15:0]     iw_q;
    logic [10:0]     w_q;
    logic [9:0]      h_q;
    logic [10:0]     x_q;
    logic [9:0]      y_q;
    gfx_pkg::pixel_t color_q;
    logic [10:0]     col;
    logic [9:0]      row;
    logic [11:0]     dst_col;
    logic [10:0]     dst_row;
    logic            in_range;
    logic            last_col;
    logic            last_pix;
    logic [16:0]     src_row;
    logic [31:0]     src_off;
    logic [31:0]     src_byte;
    gfx_pkg::pixel_t src_half;

    // Strobes while busy are dropped, clear beats draw.
    assign start = (draw || clear) && !busy;

    assign dst_col  = {1'b0, x_q} + {1'b0, col};
    assign dst_row  = {1'b0, y_q} + {1'b0, row};
    assign in_range = (dst_col < 12'(FB_WIDTH)) && (dst_row < 11'(FB_HEIGHT));
    assign last_col = (col == w_q - 11'd1);
    assign last_pix = last_col && (row == h_q - 10'd1);

    // Source halfword address, stable through READ_SRC and WRITE_PIX.
    assign src_row  = {1'b0, sy_q} + {7'd0, row};
    assign src_off  = 32'(src_row) * 32'(iw_q) + 32'(sx_q) + 32'(col);
    assign src_byte = base_q + {src_off[30:0], 1'b0};
    assign src_half = src_byte[1] ? src_rd_data[31:16] : src_rd_data[15:0];

    assign advance = (state == gfx_pkg::CLEAR_RUN) || (state == gfx_pkg::WRITE_PIX) ||
                     ((state == gfx_pkg::READ_SRC) && !in_range);

    assign src_rd_en   = (state == gfx_pkg::READ_SRC) && in_range;
    assign src_rd_addr = src_byte[AW+1:2];
    assign fb_we       = (state == gfx_pkg::CLEAR_RUN) || (state == gfx_pkg::WRITE_PIX);
    assign fb_addr     = FBAW'(32'(dst_row) * FB_WIDTH + 32'(dst_col));
    assign fb_pixel    = (state == gfx_pkg::CLEAR_RUN) ? color_q : src_half;

    // A clear walks the whole buffer as a full-screen rectangle.
    always_ff @(posedge clk_25mhz) begin
        if (start) begin
            color_q <= clear_color;
            base_q  <= src_addr;
            sx_q    <= src_x;
            sy_q    <= src_y;
            iw_q    <= img_width;
            if (clear) begin
                w_q <= 11'(FB_WIDTH);
                h_q <= 10'(FB_HEIGHT);
                x_q <= 11'd0;
                y_q <= 10'd0;
            end else begin
                w_q <= width;
                h_q <= height;
                x_q <= dst_x;
                y_q <= dst_y;
            end
        end
    end

    always_ff @(posedge clk_25mhz or negedge arst_n) begin
        if (!arst_n) begin
            state <= gfx_pkg::IDLE;
            busy  <= 1'b0;
            col   <= 11'd0;
            row   <= 10'd0;
        end else if (start) begin
            busy <= 1'b1;
            col  <= 11'd0;
            row  <= 10'd0;
            if (clear) begin
                state <= gfx_pkg::CLEAR_RUN;
            end else if ((width == 11'd0) || (height == 10'd0)) begin
                state <= gfx_pkg::DONE;
            end else begin
                state <= gfx_pkg::READ_SRC;
            end
        end else if (advance) begin
            if (last_pix) begin
                state <= gfx_pkg::DONE;
                busy  <= 1'b0;
            end else begin
                if (last_col) begin
                    col <= 11'd0;
                    row <= row + 10'd1;
                end else begin
                    col <= col + 11'd1;
                end
                if (state != gfx_pkg::CLEAR_RUN) begin
                    state <= gfx_pkg::READ_SRC;
                end
            end
        end else if (state == gfx_pkg::READ_SRC) begin
            state <= gfx_pkg::WRITE_PIX;
        end else if (state == gfx_pkg::DONE) begin
            state <= gfx_pkg::IDLE;
            busy  <= 1'b0;
        end
    end

    // Clipping keeps every write inside the framebuffer.
    assert property (@(posedge clk_25mhz) disable iff (!arst_n)
        fb_we |-> (32'(fb_addr) < FB_PIXELS));

    assert property (@(posedge clk_25mhz) disable iff (!arst_n)
        (state == gfx_pkg::IDLE) |-> !busy);

endmodule

//--- src/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer #(
    parameter int  FB_WIDTH  = 64,
    parameter int  FB_HEIGHT = 48,
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT,
    localparam int FBAW      = $clog2(FB_PIXELS),
    localparam int XW        = $clog2(FB_WIDTH),
    localparam int YW        = $clog2(FB_HEIGHT)
) (
    input  logic            clk_25mhz,
    input  logic            arst_n,
    input  logic            fb_we,
    input  logic [FBAW-1:0] fb_addr,
    input  gfx_pkg::pixel_t fb_pixel,
    input  logic            swap_req,
    input  logic            swap_on_vsync,
    input  logic            vsync,
    input  logic [XW-1:0]   scan_x,
    input  logic [YW-1:0]   scan_y,
    output gfx_pkg::pixel_t scan_pixel
);

    gfx_pkg::pixel_t pix_mem [0:1][0:FB_PIXELS-1];

    logic        front;
    logic        armed;
    logic        vs_meta;
    logic        vs_sync;
    logic        vs_prev;
    logic        vs_rise;
    logic        scan_ok;
    logic [31:0] scan_addr;

    assign vs_rise   = vs_sync && !vs_prev;
    assign scan_ok   = (32'(scan_x) < FB_WIDTH) && (32'(scan_y) < FB_HEIGHT);
    assign scan_addr = 32'(scan_y) * FB_WIDTH + 32'(scan_x);

    // Engine writes land in the back buffer.
    always_ff @(posedge clk_25mhz) begin
        if (fb_we) begin
            pix_mem[~front][fb_addr] <= fb_pixel;
        end
    end

    always_ff @(posedge clk_25mhz) begin
        if (scan_ok) begin
            scan_pixel <= pix_mem[front][scan_addr[FBAW-1:0]];
        end else begin
            scan_pixel <= '0;
        end
    end

    always_ff @(posedge clk_25mhz or negedge arst_n) begin
        if (!arst_n) begin
            front   <= 1'b0;
            armed   <= 1'b0;
            vs_meta <= 1'b0;
            vs_sync <= 1'b0;
            vs_prev <= 1'b0;
        end else begin
            vs_meta <= vsync;
            vs_sync <= vs_meta;
            vs_prev <= vs_sync;
            // Requests while armed are absorbed.
            if (armed) begin
                if (vs_rise) begin
                    front <= ~front;
                    armed <= 1'b0;
                end
            end else if (swap_req) begin
                if (swap_on_vsync) begin
                    armed <= 1'b1;
                end else begin
                    front <= ~front;
                end
            end
        end
    end

    assert property (@(posedge clk_25mhz) disable iff (!arst_n)
        (front != $past(front)) |-> $past(swap_req || (armed && vs_rise)));

endmodule

//--- src/gfx_pkg.sv
package gfx_pkg;

    // One RGB565 pixel.
    typedef logic [15:0] pixel_t;

    // Byte offsets of the control registers above the RAM.
    typedef enum logic [11:0] {
        ADDR        = 12'h000,
        ADDR_X      = 12'h004,
        ADDR_Y      = 12'h008,
        IMG_WIDTH   = 12'h00C,
        WIDTH       = 12'h010,
        HEIGHT      = 12'h014,
        X           = 12'h018,
        Y           = 12'h01C,
        DRAW        = 12'h020,
        CLEAR_COLOR = 12'h024,
        CLEAR       = 12'h028,
        BUSY        = 12'h02C,
        SWAP        = 12'h100,
        VSYNC       = 12'h108,
        VSYNCED     = 12'h10C
    } reg_offset_e;

    // Blit engine states.
    typedef enum logic [2:0] {
        IDLE,
        CLEAR_RUN,
        READ_SRC,
        WRITE_PIX,
        DONE
    } blit_state_e;

endpackage

//--- src/gfx_soc.sv
`timescale 1ns/1ps

module gfx_soc #(
    parameter int  MEM_SIZE  = 8192,
    parameter int  FB_WIDTH  = 64,
    parameter int  FB_HEIGHT = 48,
    localparam int AW        = $clog2(MEM_SIZE / 4),
    localparam int FBAW      = $clog2(FB_WIDTH * FB_HEIGHT),
    localparam int XW        = $clog2(FB_WIDTH),
    localparam int YW        = $clog2(FB_HEIGHT)
) (
    input  logic            clk_25mhz,
    input  logic            arst_n,
    input  logic            mem_valid,
    input  logic [31:0]     mem_addr,
    input  logic [31:0]     mem_wdata,
    input  logic [3:0]      mem_wstrb,
    output logic            mem_ready,
    output logic [31:0]     mem_rdata,
    input  logic            vsync,
    input  logic [XW-1:0]   scan_x,
    input  logic [YW-1:0]   scan_y,
    output gfx_pkg::pixel_t scan_pixel
);

    logic [31:0]     ram_rdata;
    logic [31:0]     reg_rdata;
    logic            ram_sel;
    logic            ram_en;
    logic            busy;
    logic            draw;
    logic            clear;
    logic            swap_req;
    logic            swap_on_vsync;
    logic [31:0]     src_addr;
    logic [15:0]     src_x;
    logic [15:0]     src_y;
    logic [15:0]     img_width;
    logic [10:0]     width;
    logic [9:0]      height;
    logic [10:0]     dst_x;
    logic [9:0]      dst_y;
    gfx_pkg::pixel_t clear_color;
    logic            src_rd_en;
    logic [AW-1:0]   src_rd_addr;
    logic [31:0]     src_rd_data;
    logic            fb_we;
    logic [FBAW-1:0] fb_addr;
    gfx_pkg::pixel_t fb_pixel;

    // Read data source follows the region captured with the request.
    assign mem_rdata = ram_sel ? ram_rdata : reg_rdata;

    sys_ram #(
        .MEM_SIZE(MEM_SIZE)
    ) i_sys_ram (
        .clk_25mhz  (clk_25mhz),
        .bus_en     (ram_en),
        .word_addr  (mem_addr[AW+1:2]),
        .wdata      (mem_wdata),
        .wstrb      (mem_wstrb),
        .rdata      (ram_rdata),
        .src_rd_en  (src_rd_en),
        .src_rd_addr(src_rd_addr),
        .src_rd_data(src_rd_data)
    );

    gpu_regs #(
        .MEM_SIZE(MEM_SIZE)
    ) i_gpu_regs (
        .clk_25mhz    (clk_25mhz),
        .arst_n       (arst_n),
        .mem_valid    (mem_valid),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_wstrb    (mem_wstrb),
        .mem_ready    (mem_ready),
        .reg_rdata    (reg_rdata),
        .ram_sel      (ram_sel),
        .ram_en       (ram_en),
        .busy         (busy),
        .vsync        (vsync),
        .draw         (draw),
        .clear        (clear),
        .swap_req     (swap_req),
        .swap_on_vsync(swap_on_vsync),
        .src_addr     (src_addr),
        .src_x        (src_x),
        .src_y        (src_y),
        .img_width    (img_width),
        .width        (width),
        .height       (height),
        .dst_x        (dst_x),
        .dst_y        (dst_y),
        .clear_color  (clear_color)
    );

    blit_engine #(
        .MEM_SIZE (MEM_SIZE),
        .FB_WIDTH (FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT)
    ) i_blit_engine (
        .clk_25mhz  (clk_25mhz),
        .arst_n     (arst_n),
        .draw       (draw),
        .clear      (clear),
        .src_addr   (src_addr),
        .src_x      (src_x),
        .src_y      (src_y),
        .img_width  (img_width),
        .width      (width),
        .height     (height),
        .dst_x      (dst_x),
        .dst_y      (dst_y),
        .clear_color(clear_color),
        .busy       (busy),
        .src_rd_en  (src_rd_en),
        .src_rd_addr(src_rd_addr),
        .src_rd_data(src_rd_data),
        .fb_we      (fb_we),
        .fb_addr    (fb_addr),
        .fb_pixel   (fb_pixel)
    );

    frame_buffer #(
        .FB_WIDTH (FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT)
    ) i_frame_buffer (
        .clk_25mhz    (clk_25mhz),
        .arst_n       (arst_n),
        .fb_we        (fb_we),
        .fb_addr      (fb_addr),
        .fb_pixel     (fb_pixel),
        .swap_req     (swap_req),
        .swap_on_vsync(swap_on_vsync),
        .vsync        (vsync),
        .scan_x       (scan_x),
        .scan_y       (scan_y),
        .scan_pixel   (scan_pixel)
    );

endmodule

//--- src/gpu_regs.sv
`timescale 1ns/1ps

module gpu_regs #(
    parameter int MEM_SIZE = 8192
) (
    input  logic            clk_25mhz,
    input  logic            arst_n,
    input  logic            mem_valid,
    input  logic [31:0]     mem_addr,
    input  logic [31:0]     mem_wdata,
    input  logic [3:0]      mem_wstrb,
    output logic            mem_ready,
    output logic [31:0]     reg_rdata,
    output logic            ram_sel,
    output logic            ram_en,
    input  logic            busy,
    input  logic            vsync,
    output logic            draw,
    output logic            clear,
    output logic            swap_req,
    output logic            swap_on_vsync,
    output logic [31:0]     src_addr,
    output logic [15:0]     src_x,
    output logic [15:0]     src_y,
    output logic [15:0]     img_width,
    output logic [10:0]     width,
    output logic [9:0]      height,
    output logic [10:0]     dst_x,
    output logic [9:0]      dst_y,
    output gfx_pkg::pixel_t clear_color
);

    logic                 accept;
    logic                 in_ram;
    logic                 in_regs;
    logic                 reg_wr;
    logic [31:0]          rel_addr;
    gfx_pkg::reg_offset_e reg_off;
    logic                 vs_meta;
    logic                 vs_sync;

    // A request is taken once, in the cycle before ready.
    assign accept   = mem_valid && !mem_ready;
    assign in_ram   = mem_addr < 32'(MEM_SIZE);
    assign rel_addr = mem_addr - 32'(MEM_SIZE);
    assign in_regs  = !in_ram && (rel_addr[31:12] == 20'd0);
    assign reg_off  = gfx_pkg::reg_offset_e'(rel_addr[11:0]);
    assign reg_wr   = accept && in_regs && (mem_wstrb != 4'd0);
    assign ram_en   = accept && in_ram;

    always_ff @(posedge clk_25mhz or negedge arst_n) begin
        if (!arst_n) begin
            mem_ready     <= 1'b0;
            ram_sel       <= 1'b0;
            reg_rdata     <= 32'd0;
            draw          <= 1'b0;
            clear         <= 1'b0;
            swap_req      <= 1'b0;
            swap_on_vsync <= 1'b1;
            vs_meta       <= 1'b0;
            vs_sync       <= 1'b0;
        end else begin
            mem_ready <= accept;
            vs_meta   <= vsync;
            vs_sync   <= vs_meta;
            draw      <= reg_wr && (reg_off == gfx_pkg::DRAW) && mem_wdata[0];
            clear     <= reg_wr && (reg_off == gfx_pkg::CLEAR) && mem_wdata[0];
            swap_req  <= reg_wr && (reg_off == gfx_pkg::SWAP) && mem_wdata[0];
            if (reg_wr && (reg_off == gfx_pkg::VSYNCED)) begin
                swap_on_vsync <= mem_wdata[0];
            end
            // Region select and status data line up with ready.
            if (accept) begin
                ram_sel   <= in_ram;
                reg_rdata <= 32'd0;
                if (in_regs) begin
                    case (reg_off)
                        gfx_pkg::BUSY:  reg_rdata <= {31'd0, busy};
                        gfx_pkg::VSYNC: reg_rdata <= {31'd0, vs_sync};
                        default:        reg_rdata <= 32'd0;
                    endcase
                end
            end
        end
    end

    // Blit parameters, truncated to each register's width.
    always_ff @(posedge clk_25mhz) begin
        if (reg_wr) begin
            case (reg_off)
                gfx_pkg::ADDR:        src_addr    <= mem_wdata;
                gfx_pkg::ADDR_X:      src_x       <= mem_wdata[15:0];
                gfx_pkg::ADDR_Y:      src_y       <= mem_wdata[15:0];
                gfx_pkg::IMG_WIDTH:   img_width   <= mem_wdata[15:0];
                gfx_pkg::WIDTH:       width       <= mem_wdata[10:0];
                gfx_pkg::HEIGHT:      height      <= mem_wdata[9:0];
                gfx_pkg::X:           dst_x       <= mem_wdata[10:0];
                gfx_pkg::Y:           dst_y       <= mem_wdata[9:0];
                gfx_pkg::CLEAR_COLOR: clear_color <= mem_wdata[15:0];
                default: ;
            endcase
        end
    end

    // Bus handshake gives one ready per request.
    assert property (@(posedge clk_25mhz) disable iff (!arst_n)
        mem_ready |=> !mem_ready);

endmodule

//--- src/sys_ram.sv
`timescale 1ns/1ps

module sys_ram #(
    parameter int  MEM_SIZE = 8192,
    localparam int WORDS    = MEM_SIZE / 4,
    localparam int AW       = $clog2(WORDS)
) (
    input  logic          clk_25mhz,
    input  logic          bus_en,
    input  logic [AW-1:0] word_addr,
    input  logic [31:0]   wdata,
    input  logic [3:0]    wstrb,
    output logic [31:0]   rdata,
    input  logic          src_rd_en,
    input  logic [AW-1:0] src_rd_addr,
    output logic [31:0]   src_rd_data
);

    logic [31:0] mem [0:WORDS-1];

    // Bus port, byte lanes written by strobe, read data registered.
    always_ff @(posedge clk_25mhz) begin
        if (bus_en) begin
            for (int i = 0; i < 4; i++) begin
                if (wstrb[i]) begin
                    mem[word_addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
            rdata <= mem[word_addr];
        end
    end

    // Engine read port.
    always_ff @(posedge clk_25mhz) begin
        if (src_rd_en) begin
            src_rd_data <= mem[src_rd_addr];
        end
    end

endmodule
